/* Makefile */
SIM  := obj_dir/Vtb_top
SRCS := $(shell grep -v '^+' verilog.f) testbench/tb_program.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module tb_top -f verilog.f -Mdir obj_dir -o Vtb_top

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/dual_core.sv */
module dual_core
    import dual_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  inst_ok,
    input  logic                  inst_ok_1,
    input  logic                  inst_ok_2,
    input  logic [XLEN-1:0]       inst_data_1,
    input  logic [XLEN-1:0]       inst_data_2,
    output logic                  inst_en,
    output logic [XLEN-1:0]       inst_addr,
    output logic [LANES-1:0]      commit_valid,
    output logic [REG_ADDR_W-1:0] commit_dest [LANES],
    output logic [XLEN-1:0]       commit_data [LANES]
);

    logic [XLEN-1:0]       head_inst [LANES];
    logic [QUEUE_PTR_W:0]  queue_count;
    logic [1:0]            pop_count;
    logic [LANES-1:0]      issue_valid;
    logic [XLEN-1:0]       issue_inst [LANES];
    logic [REG_ADDR_W-1:0] rs_addr [LANES];
    logic [REG_ADDR_W-1:0] rt_addr [LANES];
    logic [XLEN-1:0]       rs_data [LANES];
    logic [XLEN-1:0]       rt_data [LANES];

    fetch_queue u_fetch_queue (
        .clk         (clk),
        .arst_n      (arst_n),
        .inst_ok     (inst_ok),
        .inst_ok_1   (inst_ok_1),
        .inst_ok_2   (inst_ok_2),
        .inst_data_1 (inst_data_1),
        .inst_data_2 (inst_data_2),
        .pop_count   (pop_count),
        .inst_en     (inst_en),
        .inst_addr   (inst_addr),
        .head_inst   (head_inst),
        .queue_count (queue_count)
    );

    issue_ctrl u_issue_ctrl (
        .head_inst   (head_inst),
        .queue_count (queue_count),
        .pop_count   (pop_count),
        .issue_valid (issue_valid),
        .issue_inst  (issue_inst)
    );

    // Result registers double as the retire trace
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        exec_lane u_lane (
            .clk         (clk),
            .arst_n      (arst_n),
            .issue_valid (issue_valid[i]),
            .issue_inst  (issue_inst[i]),
            .rs_data     (rs_data[i]),
            .rt_data     (rt_data[i]),
            .fwd_valid   (commit_valid),
            .fwd_dest    (commit_dest),
            .fwd_data    (commit_data),
            .rs_addr     (rs_addr[i]),
            .rt_addr     (rt_addr[i]),
            .res_valid   (commit_valid[i]),
            .res_dest    (commit_dest[i]),
            .res_data    (commit_data[i])
        );
    end

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .wr_valid (commit_valid),
        .wr_dest  (commit_dest),
        .wr_data  (commit_data),
        .rs_data  (rs_data),
        .rt_data  (rt_data)
    );

endmodule

/* design/dual_pkg.sv */
package dual_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam int LANES       = 2;
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_PTR_W = 3;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f
    } opcode_e;

    // Function field of special instructions, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    // Register written by the instruction, zero if none
    function automatic logic [REG_ADDR_W-1:0] inst_dest(input logic [XLEN-1:0] inst);
        logic [REG_ADDR_W-1:0] dest;
        dest = '0;
        case (inst[31:26])
            OP_SPECIAL: begin
                case (inst[5:0])
                    FN_SLL, FN_SRL, FN_ADDU, FN_SUBU,
                    FN_AND, FN_OR, FN_XOR, FN_SLT: dest = inst[15:11];
                    default: dest = '0;
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI: dest = inst[20:16];
            default: dest = '0;
        endcase
        return dest;
    endfunction

    // Registers actually read, packed as {rs, rt}; unused sources read as zero
    function automatic logic [2*REG_ADDR_W-1:0] inst_srcs(input logic [XLEN-1:0] inst);
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        rs = '0;
        rt = '0;
        case (inst[31:26])
            OP_SPECIAL: begin
                case (inst[5:0])
                    FN_SLL, FN_SRL: rt = inst[20:16];
                    FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT: begin
                        rs = inst[25:21];
                        rt = inst[20:16];
                    end
                    default: rs = '0;
                endcase
            end
            OP_ADDIU, OP_ORI: rs = inst[25:21];
            default: rs = '0;
        endcase
        return {rs, rt};
    endfunction

endpackage

/* design/exec_lane.sv */
module exec_lane
    import dual_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  issue_valid,
    input  logic [XLEN-1:0]       issue_inst,
    input  logic [XLEN-1:0]       rs_data,
    input  logic [XLEN-1:0]       rt_data,
    input  logic [LANES-1:0]      fwd_valid,
    input  logic [REG_ADDR_W-1:0] fwd_dest [LANES],
    input  logic [XLEN-1:0]       fwd_data [LANES],
    output logic [REG_ADDR_W-1:0] rs_addr,
    output logic [REG_ADDR_W-1:0] rt_addr,
    output logic                  res_valid,
    output logic [REG_ADDR_W-1:0] res_dest,
    output logic [XLEN-1:0]       res_data
);

    typedef enum logic [1:0] {
        IMM_NONE,
        IMM_SIGN,
        IMM_ZERO,
        IMM_UPPER
    } imm_kind_e;

    logic                    ex_valid;
    logic [XLEN-1:0]         ex_inst;
    logic [2*REG_ADDR_W-1:0] srcs;
    logic [REG_ADDR_W-1:0]   dest;
    alu_op_e                 alu_op;
    imm_kind_e               imm_kind;
    logic [XLEN-1:0]         rs_val;
    logic [XLEN-1:0]         rt_val;
    logic [XLEN-1:0]         op_b;
    logic [XLEN-1:0]         alu_res;

    assign srcs    = inst_srcs(ex_inst);
    assign dest    = inst_dest(ex_inst);
    assign rs_addr = srcs[2*REG_ADDR_W-1:REG_ADDR_W];
    assign rt_addr = srcs[REG_ADDR_W-1:0];

    always_comb begin
        alu_op   = ALU_NOP;
        imm_kind = IMM_NONE;
        case (ex_inst[31:26])
            OP_SPECIAL: begin
                case (ex_inst[5:0])
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    default: alu_op = ALU_NOP;
                endcase
            end
            OP_ADDIU: begin
                alu_op   = ALU_ADD;
                imm_kind = IMM_SIGN;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                imm_kind = IMM_ZERO;
            end
            // rs reads as r0, so OR just places the immediate
            OP_LUI: begin
                alu_op   = ALU_OR;
                imm_kind = IMM_UPPER;
            end
            default: alu_op = ALU_NOP;
        endcase
        // Writes to r0 retire as no-ops
        if (dest == '0) begin
            alu_op = ALU_NOP;
        end
    end

    // Youngest producer wins, so later lanes override
    always_comb begin
        rs_val = rs_data;
        rt_val = rt_data;
        for (int l = 0; l < LANES; l++) begin
            if (fwd_valid[l] && rs_addr != '0 && fwd_dest[l] == rs_addr) begin
                rs_val = fwd_data[l];
            end
            if (fwd_valid[l] && rt_addr != '0 && fwd_dest[l] == rt_addr) begin
                rt_val = fwd_data[l];
            end
        end
    end

    always_comb begin
        case (imm_kind)
            IMM_SIGN:  op_b = {{16{ex_inst[15]}}, ex_inst[15:0]};
            IMM_ZERO:  op_b = {16'h0000, ex_inst[15:0]};
            IMM_UPPER: op_b = {ex_inst[15:0], 16'h0000};
            default:   op_b = rt_val;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_res = rs_val + op_b;
            ALU_SUB: alu_res = rs_val - op_b;
            ALU_AND: alu_res = rs_val & op_b;
            ALU_OR:  alu_res = rs_val | op_b;
            ALU_XOR: alu_res = rs_val ^ op_b;
            ALU_SLT: alu_res = XLEN'($signed(rs_val) < $signed(op_b));
            ALU_SLL: alu_res = op_b << ex_inst[10:6];
            ALU_SRL: alu_res = op_b >> ex_inst[10:6];
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            ex_valid  <= issue_valid;
            res_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_inst  <= issue_inst;
        res_dest <= dest;
        res_data <= alu_res;
    end

    // Every instruction that names a destination decodes to an ALU operation
    a_dest_has_op: assert property (
        @(posedge clk) disable iff (!arst_n)
        (ex_valid && dest != '0) |-> (alu_op != ALU_NOP)
    );

endmodule

/* design/fetch_queue.sv */
module fetch_queue
    import dual_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   inst_ok,
    input  logic                   inst_ok_1,
    input  logic                   inst_ok_2,
    input  logic [XLEN-1:0]        inst_data_1,
    input  logic [XLEN-1:0]        inst_data_2,
    input  logic [1:0]             pop_count,
    output logic                   inst_en,
    output logic [XLEN-1:0]        inst_addr,
    output logic [XLEN-1:0]        head_inst [LANES],
    output logic [QUEUE_PTR_W:0]   queue_count
);

    logic [XLEN-1:0]        mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] wr_ptr_next;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic                   wr_one;
    logic                   wr_two;
    logic [1:0]             wr_cnt;

    // Word 2 only counts together with word 1
    assign wr_one      = inst_ok && inst_ok_1;
    assign wr_two      = wr_one && inst_ok_2;
    assign wr_cnt      = 2'(wr_one) + 2'(wr_two);
    assign wr_ptr_next = wr_ptr + 1'b1;

    // Room for a full pair
    assign inst_en = (queue_count <= (QUEUE_PTR_W+1)'(QUEUE_DEPTH - 2));

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            head_inst[i] = mem[QUEUE_PTR_W'(rd_ptr + i)];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_one) begin
            mem[wr_ptr] <= inst_data_1;
        end
        if (wr_two) begin
            mem[wr_ptr_next] <= inst_data_2;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            queue_count <= '0;
            inst_addr   <= RESET_PC;
        end else begin
            wr_ptr      <= wr_ptr + QUEUE_PTR_W'(wr_cnt);
            rd_ptr      <= rd_ptr + QUEUE_PTR_W'(pop_count);
            queue_count <= queue_count + (QUEUE_PTR_W+1)'(wr_cnt)
                           - (QUEUE_PTR_W+1)'(pop_count);
            // PC moves past every accepted word
            if (wr_one) begin
                inst_addr <= inst_addr + XLEN'({wr_cnt, 2'b00});
            end
        end
    end

    // Memory may only answer a request
    a_write_needs_en: assert property (
        @(posedge clk) disable iff (!arst_n)
        (inst_ok && (inst_ok_1 || inst_ok_2)) |-> (inst_en && inst_ok_1)
    );

    a_pop_in_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        (QUEUE_PTR_W+1)'(pop_count) <= queue_count
    );

endmodule

/* design/issue_ctrl.sv */
module issue_ctrl
    import dual_pkg::*;
(
    input  logic [XLEN-1:0]      head_inst [LANES],
    input  logic [QUEUE_PTR_W:0] queue_count,
    output logic [1:0]           pop_count,
    output logic [LANES-1:0]     issue_valid,
    output logic [XLEN-1:0]      issue_inst [LANES]
);

    logic [REG_ADDR_W-1:0]   head_dest;
    logic [2*REG_ADDR_W-1:0] next_srcs;
    logic [REG_ADDR_W-1:0]   next_rs;
    logic [REG_ADDR_W-1:0]   next_rt;
    logic                    raw_hazard;

    always_comb begin
        head_dest = inst_dest(head_inst[0]);
        next_srcs = inst_srcs(head_inst[1]);
        next_rs   = next_srcs[2*REG_ADDR_W-1:REG_ADDR_W];
        next_rt   = next_srcs[REG_ADDR_W-1:0];
    end

    // Second entry reads what the head writes
    assign raw_hazard = (head_dest != '0)
                        && ((next_rs == head_dest) || (next_rt == head_dest));

    always_comb begin
        issue_valid[0] = (queue_count != '0);
        issue_valid[1] = (queue_count >= (QUEUE_PTR_W+1)'(2)) && !raw_hazard;
    end

    assign pop_count = 2'(issue_valid[0]) + 2'(issue_valid[1]);

    // Idle lanes see an all-zero word
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            issue_inst[i] = issue_valid[i] ? head_inst[i] : '0;
        end
    end

endmodule

/* design/reg_file.sv */
module reg_file
    import dual_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [REG_ADDR_W-1:0] rs_addr [LANES],
    input  logic [REG_ADDR_W-1:0] rt_addr [LANES],
    input  logic [LANES-1:0]      wr_valid,
    input  logic [REG_ADDR_W-1:0] wr_dest [LANES],
    input  logic [XLEN-1:0]       wr_data [LANES],
    output logic [XLEN-1:0]       rs_data [LANES],
    output logic [XLEN-1:0]       rt_data [LANES]
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // Old value until the edge
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            rs_data[l] = regs[rs_addr[l]];
            rt_data[l] = regs[rt_addr[l]];
        end
    end

    // Later lanes are younger, last assignment wins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                if (wr_valid[l] && wr_dest[l] != '0) begin
                    regs[wr_dest[l]] <= wr_data[l];
                end
            end
        end
    end

endmodule

/* testbench/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release just after an edge, ahead of the memory model
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

/* testbench/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Columns: instruction word, destination register, value written
// Destination 0 marks a step that writes no register

function automatic logic [31:0] encode_r(input logic [5:0] fn, input int rd, input int rs,
                                         input int rt, input int sh);
    return {6'(OP_SPECIAL), 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
endfunction

function automatic logic [31:0] encode_i(input logic [5:0] op, input int rt, input int rs,
                                         input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
endfunction

task automatic load_program();
    // ALU operations and immediate forms
    add_step(encode_i(OP_ADDIU, 1, 0, 16'h0005),     5'd1,  32'h0000_0005);
    add_step(encode_i(OP_ADDIU, 2, 0, 16'hfffd),     5'd2,  32'hffff_fffd);
    add_step(encode_r(FN_ADDU, 3, 1, 2, 0),          5'd3,  32'h0000_0002);
    add_step(encode_r(FN_SUBU, 4, 1, 2, 0),          5'd4,  32'h0000_0008);
    add_step(encode_r(FN_AND, 5, 1, 2, 0),           5'd5,  32'h0000_0005);
    add_step(encode_r(FN_OR, 6, 1, 2, 0),            5'd6,  32'hffff_fffd);
    add_step(encode_r(FN_XOR, 7, 1, 2, 0),           5'd7,  32'hffff_fff8);
    add_step(encode_r(FN_SLT, 8, 2, 1, 0),           5'd8,  32'h0000_0001);
    add_step(encode_r(FN_SLT, 9, 1, 2, 0),           5'd9,  32'h0000_0000);
    add_step(encode_r(FN_SLL, 10, 0, 1, 4),          5'd10, 32'h0000_0050);
    add_step(encode_r(FN_SRL, 11, 0, 2, 28),         5'd11, 32'h0000_000f);
    add_step(encode_i(OP_LUI, 12, 0, 16'h1234),      5'd12, 32'h1234_0000);
    add_step(encode_i(OP_ORI, 12, 12, 16'h5678),     5'd12, 32'h1234_5678);
    add_step(encode_i(OP_ORI, 13, 0, 16'h8000),      5'd13, 32'h0000_8000);
    add_step(encode_i(OP_ADDIU, 14, 13, 16'h8000),   5'd14, 32'h0000_0000);
    // Dependent chains
    add_step(encode_i(OP_ADDIU, 15, 0, 16'h0001),    5'd15, 32'h0000_0001);
    add_step(encode_r(FN_ADDU, 15, 15, 15, 0),       5'd15, 32'h0000_0002);
    add_step(encode_r(FN_ADDU, 15, 15, 15, 0),       5'd15, 32'h0000_0004);
    add_step(encode_r(FN_ADDU, 16, 15, 1, 0),        5'd16, 32'h0000_0009);
    add_step(encode_i(OP_ADDIU, 17, 0, 16'h0100),    5'd17, 32'h0000_0100);
    add_step(encode_i(OP_ADDIU, 18, 0, 16'h0200),    5'd18, 32'h0000_0200);
    add_step(encode_r(FN_ADDU, 19, 17, 18, 0),       5'd19, 32'h0000_0300);
    // Same register written by both lanes of a pair
    add_step(encode_i(OP_ADDIU, 20, 0, 16'h0007),    5'd20, 32'h0000_0007);
    add_step(encode_i(OP_ADDIU, 20, 0, 16'h0009),    5'd20, 32'h0000_0009);
    add_step(encode_r(FN_ADDU, 21, 20, 0, 0),        5'd21, 32'h0000_0009);
    // Register 0 and undefined encodings
    add_step(encode_i(OP_ADDIU, 0, 0, 16'h0055),     5'd0,  32'h0000_0000);
    add_step(encode_r(FN_ADDU, 22, 0, 1, 0),         5'd22, 32'h0000_0005);
    add_step(encode_i(6'h3f, 0, 0, 16'h0000),        5'd0,  32'h0000_0000);
    add_step(encode_i(OP_SLTI, 23, 1, 16'h000a),     5'd0,  32'h0000_0000);
    add_step(encode_r(6'h18, 24, 1, 2, 0),           5'd0,  32'h0000_0000);
    add_step(encode_r(FN_ADDU, 24, 23, 24, 0),       5'd24, 32'h0000_0000);
    add_step(encode_r(FN_XOR, 25, 12, 6, 0),         5'd25, 32'hedcb_a985);
    add_step(encode_r(FN_SLT, 26, 25, 12, 0),        5'd26, 32'h0000_0001);
    add_step(encode_r(FN_SUBU, 27, 0, 1, 0),         5'd27, 32'hffff_fffb);
    add_step(encode_r(FN_SLL, 0, 0, 1, 3),           5'd0,  32'h0000_0000);
    add_step(encode_r(FN_OR, 28, 0, 0, 0),           5'd28, 32'h0000_0000);
    add_step(encode_r(FN_SRL, 29, 0, 12, 16),        5'd29, 32'h0000_1234);
    add_step(encode_r(FN_ADDU, 30, 29, 26, 0),       5'd30, 32'h0000_1235);
endtask

`endif

/* testbench/tb_top.sv */
module tb_top
    import dual_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] LFSR_SEED    = 16'd57;
    localparam int          STEP_CYCLES  = 40;
    localparam int          EXTRA_CYCLES = 100;

    logic                  clk;
    logic                  arst_n;
    logic                  inst_ok;
    logic                  inst_ok_1;
    logic                  inst_ok_2;
    logic [XLEN-1:0]       inst_data_1;
    logic [XLEN-1:0]       inst_data_2;
    logic                  inst_en;
    logic [XLEN-1:0]       inst_addr;
    logic [LANES-1:0]      commit_valid;
    logic [REG_ADDR_W-1:0] commit_dest [LANES];
    logic [XLEN-1:0]       commit_data [LANES];

    logic [31:0] prog_inst [$];
    logic [4:0]  prog_dest [$];
    logic [31:0] prog_value [$];
    logic [31:0] model_regs [32];
    logic [15:0] lfsr;
    int          errors = 0;
    int          commit_count = 0;
    int          dual_commits = 0;

    tb_clock clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    dual_core dut_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_ok      (inst_ok),
        .inst_ok_1    (inst_ok_1),
        .inst_ok_2    (inst_ok_2),
        .inst_data_1  (inst_data_1),
        .inst_data_2  (inst_data_2),
        .inst_en      (inst_en),
        .inst_addr    (inst_addr),
        .commit_valid (commit_valid),
        .commit_dest  (commit_dest),
        .commit_data  (commit_data)
    );

    task automatic add_step(input logic [31:0] inst, input logic [4:0] dest,
                            input logic [31:0] value);
        prog_inst.push_back(inst);
        prog_dest.push_back(dest);
        prog_value.push_back(value);
    endtask

    `include "tb_program.svh"

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hb400;
        end
        return state >> 1;
    endfunction

    // No-ops past the end of the program
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if ((addr >> 2) < prog_inst.size()) begin
            return prog_inst[addr >> 2];
        end
        return 32'h0000_0000;
    endfunction

    task automatic model_exec(input logic [31:0] inst, output logic [4:0] dest,
                              output logic [31:0] value);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        a     = model_regs[inst[25:21]];
        b     = model_regs[inst[20:16]];
        sh    = inst[10:6];
        dest  = '0;
        value = '0;
        case (inst[31:26])
            OP_SPECIAL: begin
                dest = inst[15:11];
                case (inst[5:0])
                    FN_ADDU: value = a + b;
                    FN_SUBU: value = a - b;
                    FN_AND:  value = a & b;
                    FN_OR:   value = a | b;
                    FN_XOR:  value = a ^ b;
                    FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:  value = b << sh;
                    FN_SRL:  value = b >> sh;
                    default: dest = '0;
                endcase
            end
            OP_ADDIU: begin
                dest  = inst[20:16];
                value = a + {{16{inst[15]}}, inst[15:0]};
            end
            OP_ORI: begin
                dest  = inst[20:16];
                value = a | {16'h0000, inst[15:0]};
            end
            OP_LUI: begin
                dest  = inst[20:16];
                value = {inst[15:0], 16'h0000};
            end
            default: dest = '0;
        endcase
        // r0 stays zero
        if (dest == '0) begin
            value = '0;
        end else begin
            model_regs[dest] = value;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic verify_table();
        logic [4:0]  dest;
        logic [31:0] value;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < prog_inst.size(); i++) begin
            model_exec(prog_inst[i], dest, value);
            check_value($sformatf("table dest step %0d", i), 32'(prog_dest[i]), 32'(dest));
            check_value($sformatf("table value step %0d", i), prog_value[i], value);
        end
    endtask

    task automatic check_commit(input int lane);
        logic [4:0]  exp_dest;
        logic [31:0] exp_value;
        exp_dest  = '0;
        exp_value = '0;
        if (commit_count < prog_inst.size()) begin
            exp_dest  = prog_dest[commit_count];
            exp_value = prog_value[commit_count];
        end
        check_value($sformatf("commit_dest[%0d] step %0d", lane, commit_count),
                    32'(commit_dest[lane]), 32'(exp_dest));
        if (exp_dest != '0) begin
            check_value($sformatf("commit_data[%0d] step %0d", lane, commit_count),
                        commit_data[lane], exp_value);
        end
        commit_count++;
    endtask

    // Instruction memory, answers a request in the same cycle
    initial begin
        logic give;
        logic second;
        inst_ok     = 1'b0;
        inst_ok_1   = 1'b0;
        inst_ok_2   = 1'b0;
        inst_data_1 = '0;
        inst_data_2 = '0;
        lfsr        = LFSR_SEED;
        forever begin
            @(posedge clk);
            #2;
            give   = 1'b0;
            second = 1'b0;
            if (arst_n && inst_en) begin
                lfsr   = lfsr_step(lfsr);
                give   = lfsr[0];
                lfsr   = lfsr_step(lfsr);
                second = lfsr[0];
            end
            inst_ok     = give;
            inst_ok_1   = give;
            inst_ok_2   = give && second;
            inst_data_1 = fetch_word(inst_addr);
            inst_data_2 = fetch_word(inst_addr + 32'd4);
        end
    end

    // Lane 0 holds the older instruction
    always @(negedge clk) begin
        if (arst_n) begin
            if (commit_valid[1] && !commit_valid[0]) begin
                errors++;
                $display("Error at %0t ns: lane 1 committed without lane 0", $time);
            end
            if (commit_valid[0] && commit_valid[1]) begin
                dual_commits++;
            end
            for (int l = 0; l < LANES; l++) begin
                if (commit_valid[l]) begin
                    check_commit(l);
                end
            end
        end
    end

    initial begin
        int limit;
        #1;
        limit = STEP_CYCLES * prog_inst.size() + EXTRA_CYCLES;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles: %0d of %0d instructions committed",
                 limit, commit_count, prog_inst.size());
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        load_program();
        verify_table();
        @(posedge arst_n);
        @(negedge clk);
        check_value("commit_valid", 32'(commit_valid), 32'd0);
        check_value("inst_en", 32'(inst_en), 32'd1);
        check_value("inst_addr", inst_addr, RESET_PC);
        while (commit_count < prog_inst.size()) begin
            @(negedge clk);
        end
        // Trailing no-ops are checked as well
        repeat (4) @(negedge clk);
        @(posedge clk);
        if (dual_commits == 0) begin
            errors++;
            $display("No cycle committed on both lanes, so pairing was never exercised");
        end
        $display("Summary: %0d errors, %0d instructions committed, %0d dual commits",
                 errors, commit_count, dual_commits);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+testbench
design/dual_pkg.sv
design/fetch_queue.sv
design/issue_ctrl.sv
design/exec_lane.sv
design/reg_file.sv
design/dual_core.sv
testbench/tb_clock.sv
testbench/tb_top.sv
